// ==== sim/tag_lookup_stim.txt ====
# W idx valid key rci | L pu key status name | R pu addr data name | D cycles
# all numbers hex except D cycles; consecutive R lines to different PUs share a cycle
L 0 1234 0 no_match
R 0 0 00000000 no_match_status
W 0 1 aaaa 101
W 1 1 aaaa 102
W 2 1 aaaa 103
W 3 1 aaaa 104
W 4 1 aaaa 105
W 5 1 aaaa 106
W 6 1 aaaa 107
W 7 1 aaaa 108
W 8 1 aaaa 109
W 9 1 aaaa 10a
W a 1 5555 201
W b 0 5555 2ff
W c 1 5555 202
W d 1 7777 3aa
W e 1 5555 203
L 1 aaaa 8 ten_hits
L 2 aaaa 8 ten_hits_pu2
L 2 5555 3 three_hits
L 3 7777 1 one_hit
D 2
R 0 0 00000000 multi_pu0
R 1 4 01070108 multi_pu1
R 2 1 02010202 multi_pu2
R 3 0 00000001 multi_pu3
D 1
R 2 0 00000003 three_hits_status
R 1 1 01010102 ten_hits_w1
D 1
R 2 2 02030104 three_hits_w2
R 1 0 00000008 ten_hits_status
D 1
R 2 3 01050106 overwrite_kept_w3
R 1 3 01050106 ten_hits_w3

// ==== flist.f ====
+incdir+source
source/tag_lookup_pkg.sv
source/tag_table.sv
source/tag_scan_counter.sv
source/tag_lookup_fsm.sv
source/ram_1r1w.sv
source/tag_result_mem.sv
source/tag_lookup_top.sv
sim/tb_tag_lookup.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the tag lookup testbench with Verilator and run it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f flist.f --top-module tb_tag_lookup \
	-Mdir obj_dir -o sim_tag_lookup
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/sim_tag_lookup
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

// ==== sim/tb_tag_lookup.sv ====
`include "tag_lookup_defs.svh"

module tb_tag_lookup;

	timeunit 1ns;
	timeprecision 1ps;

	import tag_lookup_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 16;
	localparam int DONE_LAT = `TAG_TABLE_DEPTH + 2; // accept edge to lookup_done.
	localparam int ACK_LAT = 3;
	localparam int WORDS = 2 ** `TAG_RESULT_DEPTH_NBITS;

	logic clk = 1'b0;
	logic arst_n;
	logic lookup_valid;
	lookup_req_t lookup_req;
	logic lookup_ready;
	logic lookup_done;
	logic cfg_wr;
	table_idx_t cfg_idx;
	tag_entry_t cfg_entry;
	logic [`TAG_NUM_PU-1:0] io_req;
	io_cmd_t io_cmd [`TAG_NUM_PU];
	logic [`TAG_NUM_PU-1:0] io_ack;
	logic [`TAG_PU_WIDTH_NBITS-1:0] io_ack_data [`TAG_NUM_PU];

	// reference model of the table and the result memories.
	tag_entry_t shadow_tab [`TAG_TABLE_DEPTH];
	logic [15:0] shadow_h [`TAG_NUM_PU][WORDS];
	logic [15:0] shadow_l [`TAG_NUM_PU][WORDS];
	bit known_h [`TAG_NUM_PU][WORDS]; // half written at least once.
	bit known_l [`TAG_NUM_PU][WORDS];

	// reads collected for one cycle.
	logic [`TAG_NUM_PU-1:0] rd_pend;
	result_addr_t rd_addr [`TAG_NUM_PU];
	logic [31:0] rd_exp [`TAG_NUM_PU];
	string rd_name [`TAG_NUM_PU];

	string stim_lines [$];
	int n_stim = 0;

	tag_lookup_top i_dut (
		.clk(clk),
		.arst_n(arst_n),
		.lookup_valid(lookup_valid),
		.lookup_req(lookup_req),
		.lookup_ready(lookup_ready),
		.lookup_done(lookup_done),
		.cfg_wr(cfg_wr),
		.cfg_idx(cfg_idx),
		.cfg_entry(cfg_entry),
		.io_req(io_req),
		.io_cmd(io_cmd),
		.io_ack(io_ack),
		.io_ack_data(io_ack_data)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "stopping after the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		abort_run($sformatf("ERROR %s: expected %0h, actual %0h", name, exp, act));
	endtask

	task automatic load_stimulus();
		int fd;
		int rc;
		string line;
		fd = $fopen("sim/tag_lookup_stim.txt", "r");
		assert (fd != 0) else abort_run("cannot open the stimulus file sim/tag_lookup_stim.txt");
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
				stim_lines.push_back(line);
			end
		end
		$fclose(fd);
		n_stim = stim_lines.size();
	endtask

	task automatic write_entry(input table_idx_t idx, input tag_entry_t entry);
		shadow_tab[idx] = entry;
		cfg_wr = 1'b1;
		cfg_idx = idx;
		cfg_entry = entry;
		@(negedge clk);
		cfg_wr = 1'b0;
	endtask

	task automatic run_lookup(input pu_id_t pu, input tag_key_t key,
			input logic [31:0] exp_status, input string name);
		int cnt;
		int n;
		bit accepted;
		bit seen;
		result_addr_t addr;
		cnt = 0;
		// hits in table order with only the first eight stored.
		for (int i = 0; i < `TAG_TABLE_DEPTH; i++) begin
			if (shadow_tab[i].valid && shadow_tab[i].key == key && cnt < `TAG_MAX_RESULTS) begin
				addr = result_addr_t'(cnt / 2 + 1);
				if (cnt % 2 == 1) begin
					shadow_l[pu][addr] = 16'(shadow_tab[i].rci);
					known_l[pu][addr] = 1'b1;
				end else begin
					shadow_h[pu][addr] = 16'(shadow_tab[i].rci);
					known_h[pu][addr] = 1'b1;
				end
				cnt++;
			end
		end
		shadow_l[pu][0] = 16'(cnt);
		shadow_h[pu][0] = '0;
		known_l[pu][0] = 1'b1;
		known_h[pu][0] = 1'b1;
		assert (exp_status == cnt) else report_mismatch({name, " stimulus status"}, cnt, exp_status);

		lookup_valid = 1'b1;
		lookup_req.pu = pu;
		lookup_req.key = key;
		accepted = 1'b0;
		while (!accepted) begin
			accepted = lookup_ready; // stable until the next rising edge.
			@(negedge clk);
		end
		lookup_valid = 1'b0;

		n = 1;
		seen = 1'b0;
		while (!seen) begin
			assert (!lookup_ready)
				else abort_run($sformatf("lookup_ready went high during the scan of %s", name));
			if (lookup_done) begin
				seen = 1'b1;
			end else begin
				assert (n < DONE_LAT + 8) else abort_run($sformatf("no lookup_done for %s", name));
				@(negedge clk);
				n++;
			end
		end
		assert (n == DONE_LAT) else report_mismatch({name, " done latency"}, DONE_LAT, n);
		@(negedge clk);
		assert (lookup_ready && !lookup_done)
			else abort_run($sformatf("no ready after the lookup_done pulse of %s", name));
	endtask

	task automatic issue_reads();
		logic [`TAG_NUM_PU-1:0] got;
		int n;
		if (rd_pend != '0) begin
			io_req = rd_pend;
			for (int p = 0; p < `TAG_NUM_PU; p++) begin
				io_cmd[p].addr = rd_addr[p];
			end
			got = '0;
			n = 0;
			while (got != rd_pend && n < ACK_LAT + 5) begin
				@(negedge clk);
				n++;
				io_req = '0; // one-cycle request.
				for (int p = 0; p < `TAG_NUM_PU; p++) begin
					if (io_ack[p]) begin
						assert (rd_pend[p] && !got[p])
							else abort_run($sformatf("unexpected ack on PU %0d", p));
						assert (n == ACK_LAT) else report_mismatch({rd_name[p], " ack latency"},
							ACK_LAT, n);
						assert (io_ack_data[p] == rd_exp[p])
							else report_mismatch(rd_name[p], rd_exp[p], io_ack_data[p]);
						got[p] = 1'b1;
					end else begin
						assert (io_ack_data[p] == '0) else report_mismatch(
							$sformatf("PU %0d data without ack", p), '0, io_ack_data[p]);
					end
				end
			end
			assert (got == rd_pend) else abort_run("a read request got no ack");
			rd_pend = '0;
		end
	endtask

	task automatic add_read(input pu_id_t pu, input result_addr_t addr,
			input logic [31:0] exp, input string name);
		if (rd_pend[pu]) begin
			issue_reads();
		end
		assert (known_h[pu][addr] && known_l[pu][addr]) else abort_run($sformatf(
			"stimulus %s reads word %0d of PU %0d before it was written", name, addr, pu));
		assert (exp == {shadow_h[pu][addr], shadow_l[pu][addr]})
			else report_mismatch({name, " stimulus data"},
				{shadow_h[pu][addr], shadow_l[pu][addr]}, exp);
		rd_pend[pu] = 1'b1;
		rd_addr[pu] = addr;
		rd_exp[pu] = exp;
		rd_name[pu] = name;
	endtask

	task automatic run_line(input string line);
		byte kind;
		int rc;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;
		string name;
		tag_entry_t entry;
		kind = line.getc(0);
		if (kind != "R") begin
			issue_reads();
		end
		case (kind)
			"W": begin
				rc = $sscanf(line, "W %h %h %h %h", f1, f2, f3, f4);
				assert (rc == 4) else abort_run({"malformed table write: ", line});
				entry.valid = f2[0];
				entry.key = tag_key_t'(f3);
				entry.rci = rci_t'(f4);
				write_entry(table_idx_t'(f1), entry);
			end
			"L": begin
				rc = $sscanf(line, "L %h %h %h %s", f1, f2, f3, name);
				assert (rc == 4) else abort_run({"malformed lookup: ", line});
				run_lookup(pu_id_t'(f1), tag_key_t'(f2), f3, name);
			end
			"R": begin
				rc = $sscanf(line, "R %h %h %h %s", f1, f2, f3, name);
				assert (rc == 4) else abort_run({"malformed read: ", line});
				add_read(pu_id_t'(f1), result_addr_t'(f2), f3, name);
			end
			"D": begin
				rc = $sscanf(line, "D %d", f1);
				assert (rc == 1) else abort_run({"malformed idle wait: ", line});
				repeat (f1) @(negedge clk);
			end
			default: abort_run({"unknown stimulus line: ", line});
		endcase
	endtask

	initial begin
		arst_n = 1'b0;
		lookup_valid = 1'b0;
		lookup_req = '0;
		cfg_wr = 1'b0;
		cfg_idx = '0;
		cfg_entry = '0;
		io_req = '0;
		rd_pend = '0;
		for (int p = 0; p < `TAG_NUM_PU; p++) begin
			io_cmd[p] = '0;
			for (int a = 0; a < WORDS; a++) begin
				known_h[p][a] = 1'b0;
				known_l[p][a] = 1'b0;
			end
		end
		for (int i = 0; i < `TAG_TABLE_DEPTH; i++) begin
			shadow_tab[i] = '0; // table resets to invalid.
		end
		load_stimulus();
		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		foreach (stim_lines[i]) begin
			run_line(stim_lines[i]);
		end
		issue_reads();
		$display("TEST PASSED");
		$finish;
	end

	// watchdog sized from the stimulus length.
	initial begin
		wait (n_stim > 0);
		#(n_stim * (`TAG_TABLE_DEPTH + 10) * CLK_PERIOD);
		abort_run("timeout, the stimulus did not finish in time");
	end

endmodule

// ==== source/tag_lookup_top.sv ====
`include "tag_lookup_defs.svh"

module tag_lookup_top (
	input logic clk,
	input logic arst_n,
	input logic lookup_valid,
	input tag_lookup_pkg::lookup_req_t lookup_req,
	output logic lookup_ready,
	output logic lookup_done,
	input logic cfg_wr,
	input tag_lookup_pkg::table_idx_t cfg_idx,
	input tag_lookup_pkg::tag_entry_t cfg_entry,
	input logic [`TAG_NUM_PU-1:0] io_req,
	input tag_lookup_pkg::io_cmd_t io_cmd [`TAG_NUM_PU],
	output logic [`TAG_NUM_PU-1:0] io_ack,
	output logic [`TAG_PU_WIDTH_NBITS-1:0] io_ack_data [`TAG_NUM_PU]
);

	import tag_lookup_pkg::*;

	table_idx_t scan_idx;
	logic scan_last;
	logic scan_clear;
	logic scan_step;
	tag_entry_t rd_entry;
	tag_result_t tag_result;
	tag_status_t tag_status;

	tag_table i_table (
		.clk(clk),
		.arst_n(arst_n),
		.cfg_wr(cfg_wr),
		.cfg_idx(cfg_idx),
		.cfg_entry(cfg_entry),
		.rd_idx(scan_idx),
		.rd_entry(rd_entry)
	);

	tag_scan_counter i_counter (
		.clk(clk),
		.arst_n(arst_n),
		.scan_clear(scan_clear),
		.scan_step(scan_step),
		.scan_idx(scan_idx),
		.scan_last(scan_last)
	);

	tag_lookup_fsm i_fsm (
		.clk(clk),
		.arst_n(arst_n),
		.lookup_valid(lookup_valid),
		.lookup_req(lookup_req),
		.lookup_ready(lookup_ready),
		.scan_last(scan_last),
		.scan_clear(scan_clear),
		.scan_step(scan_step),
		.rd_entry(rd_entry),
		.tag_result(tag_result),
		.tag_status(tag_status),
		.lookup_done(lookup_done)
	);

	tag_result_mem #(
		.NUM_PU(`TAG_NUM_PU)
	) i_result_mem (
		.clk(clk),
		.arst_n(arst_n),
		.tag_result(tag_result),
		.tag_status(tag_status),
		.io_req(io_req),
		.io_cmd(io_cmd),
		.io_ack(io_ack),
		.io_ack_data(io_ack_data)
	);

endmodule

// ==== source/tag_result_mem.sv ====
`include "tag_lookup_defs.svh"

module tag_result_mem #(
	parameter int NUM_PU = `TAG_NUM_PU
) (
	input logic clk,
	input logic arst_n,
	input tag_lookup_pkg::tag_result_t tag_result,
	input tag_lookup_pkg::tag_status_t tag_status,
	input logic [NUM_PU-1:0] io_req,
	input tag_lookup_pkg::io_cmd_t io_cmd [NUM_PU],
	output logic [NUM_PU-1:0] io_ack,
	output logic [`TAG_PU_WIDTH_NBITS-1:0] io_ack_data [NUM_PU]
);

	import tag_lookup_pkg::*;

	localparam int HALF = `TAG_PU_WIDTH_NBITS / 2;

	logic [NUM_PU-1:0] req_d1;
	logic [NUM_PU-1:0] req_d2;
	io_cmd_t cmd_d1 [NUM_PU];

	logic [NUM_PU-1:0] wr_l;
	logic [NUM_PU-1:0] wr_h;
	result_addr_t waddr;
	logic [HALF-1:0] wdata_l;
	logic [HALF-1:0] wdata_h;
	logic [HALF-1:0] rdata_l [NUM_PU];
	logic [HALF-1:0] rdata_h [NUM_PU];

	// status goes to word 0, result n to word n/2+1.
	assign waddr = tag_status.valid ? '0 :
		result_addr_t'(tag_result.num >> 1) + result_addr_t'(1);
	assign wdata_l = tag_status.valid ? HALF'(tag_status.count) : HALF'(tag_result.rci);
	assign wdata_h = tag_status.valid ? '0 : HALF'(tag_result.rci);

	for (genvar p = 0; p < NUM_PU; p++) begin : g_pu
		logic st_sel;
		logic res_sel;

		assign st_sel = tag_status.valid & (tag_status.pu == pu_id_t'(p));
		assign res_sel = tag_result.valid & ~tag_status.valid &
			(tag_result.pu == pu_id_t'(p));
		assign wr_l[p] = st_sel | (res_sel & tag_result.num[0]); // odd ordinal.
		assign wr_h[p] = st_sel | (res_sel & ~tag_result.num[0]);

		ram_1r1w #(
			.WIDTH(HALF),
			.DEPTH_NBITS(`TAG_RESULT_DEPTH_NBITS)
		) i_ram_h (
			.clk(clk),
			.wr(wr_h[p]),
			.waddr(waddr),
			.din(wdata_h),
			.raddr(cmd_d1[p].addr),
			.dout(rdata_h[p])
		);

		ram_1r1w #(
			.WIDTH(HALF),
			.DEPTH_NBITS(`TAG_RESULT_DEPTH_NBITS)
		) i_ram_l (
			.clk(clk),
			.wr(wr_l[p]),
			.waddr(waddr),
			.din(wdata_l),
			.raddr(cmd_d1[p].addr),
			.dout(rdata_l[p])
		);
	end

	always_ff @(posedge clk) begin
		cmd_d1 <= io_cmd;
	end

	// request pipeline lines up with the registered RAM read.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_d1 <= '0;
			req_d2 <= '0;
			io_ack <= '0;
			for (int i = 0; i < NUM_PU; i++) begin
				io_ack_data[i] <= '0;
			end
		end else begin
			req_d1 <= io_req;
			req_d2 <= req_d1;
			io_ack <= req_d2;
			for (int i = 0; i < NUM_PU; i++) begin
				io_ack_data[i] <= req_d2[i] ? {rdata_h[i], rdata_l[i]} : '0;
			end
		end
	end

endmodule

// ==== source/ram_1r1w.sv ====
module ram_1r1w #(
	parameter int WIDTH = 16,
	parameter int DEPTH_NBITS = 3
) (
	input logic clk,
	input logic wr,
	input logic [DEPTH_NBITS-1:0] waddr,
	input logic [WIDTH-1:0] din,
	input logic [DEPTH_NBITS-1:0] raddr,
	output logic [WIDTH-1:0] dout
);

	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
		dout <= mem[raddr]; // old data on a same-cycle write.
	end

endmodule

// ==== source/tag_lookup_fsm.sv ====
`include "tag_lookup_defs.svh"

module tag_lookup_fsm (
	input logic clk,
	input logic arst_n,
	input logic lookup_valid,
	input tag_lookup_pkg::lookup_req_t lookup_req,
	output logic lookup_ready,
	input logic scan_last,
	output logic scan_clear,
	output logic scan_step,
	input tag_lookup_pkg::tag_entry_t rd_entry,
	output tag_lookup_pkg::tag_result_t tag_result,
	output tag_lookup_pkg::tag_status_t tag_status,
	output logic lookup_done
);

	import tag_lookup_pkg::*;

	lookup_state_e state;
	lookup_state_e state_nxt;
	lookup_req_t req_q;
	lookup_status_t hit_cnt;
	logic accept;
	logic cmp_vld;
	logic hit;
	logic store;

	assign accept = lookup_valid & lookup_ready;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (accept) begin
					state_nxt = ST_SCAN;
				end
			end
			ST_SCAN: begin
				if (scan_last) begin
					state_nxt = ST_DRAIN;
				end
			end
			ST_DRAIN: state_nxt = ST_STATUS; // compare of the last entry.
			ST_STATUS: state_nxt = ST_IDLE;
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			lookup_ready <= 1'b0;
			cmp_vld <= 1'b0;
			hit_cnt <= '0;
		end else begin
			state <= state_nxt;
			lookup_ready <= (state_nxt == ST_IDLE);
			cmp_vld <= (state == ST_SCAN); // table read lags the index by one.
			if (accept) begin
				hit_cnt <= '0;
			end else if (store) begin
				hit_cnt <= hit_cnt + lookup_status_t'(1);
			end
		end
	end

	// request held for the whole scan.
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= lookup_req;
		end
	end

	assign scan_clear = accept;
	assign scan_step = (state == ST_SCAN) & ~scan_last;

	assign hit = cmp_vld & rd_entry.valid & (rd_entry.key == req_q.key);
	assign store = hit & (hit_cnt < lookup_status_t'(`TAG_MAX_RESULTS)); // first eight only.

	assign tag_result.valid = store;
	assign tag_result.pu = req_q.pu;
	assign tag_result.num = result_num_t'(hit_cnt);
	assign tag_result.rci = rd_entry.rci;

	assign tag_status.valid = (state == ST_STATUS);
	assign tag_status.pu = req_q.pu;
	assign tag_status.count = hit_cnt;

	assign lookup_done = (state == ST_STATUS);

endmodule

// ==== source/tag_scan_counter.sv ====
`include "tag_lookup_defs.svh"

module tag_scan_counter (
	input logic clk,
	input logic arst_n,
	input logic scan_clear,
	input logic scan_step,
	output tag_lookup_pkg::table_idx_t scan_idx,
	output logic scan_last
);

	import tag_lookup_pkg::*;

	localparam table_idx_t LAST_IDX = table_idx_t'(`TAG_TABLE_DEPTH - 1);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_idx <= '0;
		end else if (scan_clear) begin
			scan_idx <= '0; // new lookup starts at entry 0.
		end else if (scan_step) begin
			scan_idx <= scan_idx + table_idx_t'(1);
		end
	end

	// final entry issued this cycle.
	assign scan_last = (scan_idx == LAST_IDX);

endmodule

// ==== source/tag_table.sv ====
`include "tag_lookup_defs.svh"

module tag_table (
	input logic clk,
	input logic arst_n,
	input logic cfg_wr,
	input tag_lookup_pkg::table_idx_t cfg_idx,
	input tag_lookup_pkg::tag_entry_t cfg_entry,
	input tag_lookup_pkg::table_idx_t rd_idx,
	output tag_lookup_pkg::tag_entry_t rd_entry
);

	import tag_lookup_pkg::*;

	tag_entry_t entries [`TAG_TABLE_DEPTH];

	// every entry invalid out of reset.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `TAG_TABLE_DEPTH; i++) begin
				entries[i] <= '0;
			end
		end else if (cfg_wr) begin
			entries[cfg_idx] <= cfg_entry;
		end
	end

	// registered read one cycle behind the index.
	always_ff @(posedge clk) begin
		rd_entry <= entries[rd_idx];
	end

endmodule

// ==== source/tag_lookup_pkg.sv ====
`include "tag_lookup_defs.svh"

package tag_lookup_pkg;

	typedef logic [$clog2(`TAG_NUM_PU)-1:0] pu_id_t;
	typedef logic [`TAG_KEY_NBITS-1:0] tag_key_t;
	typedef logic [`TAG_RCI_NBITS-1:0] rci_t;
	typedef logic [`TAG_TABLE_IDX_NBITS-1:0] table_idx_t;
	typedef logic [$clog2(`TAG_MAX_RESULTS)-1:0] result_num_t; // ordinal within a lookup.
	typedef logic [$clog2(`TAG_MAX_RESULTS+1)-1:0] lookup_status_t; // 0..8 results.
	typedef logic [`TAG_RESULT_DEPTH_NBITS-1:0] result_addr_t;

	typedef struct packed {
		logic valid;
		tag_key_t key;
		rci_t rci;
	} tag_entry_t;

	typedef struct packed {
		pu_id_t pu;
		tag_key_t key;
	} lookup_req_t;

	typedef struct packed {
		logic valid;
		pu_id_t pu;
		result_num_t num;
		rci_t rci;
	} tag_result_t;

	typedef struct packed {
		logic valid;
		pu_id_t pu;
		lookup_status_t count;
	} tag_status_t;

	typedef struct packed {
		result_addr_t addr;
	} io_cmd_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SCAN,
		ST_DRAIN,
		ST_STATUS
	} lookup_state_e;

endpackage

// ==== source/tag_lookup_defs.svh ====
`ifndef TAG_LOOKUP_DEFS_SVH
`define TAG_LOOKUP_DEFS_SVH

// processing units served by the lookup block.
`define TAG_NUM_PU 4

// tag table geometry.
`define TAG_TABLE_DEPTH 16
`define TAG_TABLE_IDX_NBITS 4

// entry fields.
`define TAG_KEY_NBITS 16
`define TAG_RCI_NBITS 12

// per-PU read data split into two half words in the memory.
`define TAG_PU_WIDTH_NBITS 32

// result memory with the status in word 0 and the results in words 1..4.
`define TAG_RESULT_DEPTH_NBITS 3
`define TAG_MAX_RESULTS 8

`endif
